// ==== sources.f ====
design/imager_pkg.sv
design/imager_regs.sv
design/pattern_imager.sv
design/imager_rx.sv
design/raw_to_32.sv
design/stream_capture.sv
design/imager_top.sv
verification/imager_tb.sv

// ==== verification/imager_tb.sv ====
module imager_tb import imager_pkg::*;;
   localparam int depth = 16;

   logic                  clk = 1'b0;
   logic                  resetb;
   logic [term_width-1:0] term_addr;
   logic [reg_width-1:0]  reg_addr;
   logic [reg_width-1:0]  reg_datai;
   logic                  write;
   logic                  read_mode;
   logic                  read;
   logic [reg_width-1:0]  reg_datao;
   logic                  read_rdy;
   logic [term_width-1:0] transfer_status;

   logic                  check_on = 1'b0;
   logic                  check_data = 1'b0;
   logic [reg_width-1:0]  exp_data;
   logic [term_width-1:0] exp_status;
   logic                  exp_rdy;
   string                 test_name = "reset";
   logic [reg_width-1:0]  exp_q[$];
   logic [31:0]           rng = 32'hd10f_d6df;
   int                    rnd_rows[4];
   int                    rnd_cols[4];
   logic [9:0]            rnd_base[4];
   int                    cycles = 0;
   int                    cycle_limit = 0;

   imager_top #(.capture_depth(depth)) dut0 (
      .clk(clk), .resetb(resetb), .term_addr(term_addr), .reg_addr(reg_addr),
      .reg_datai(reg_datai), .write(write), .read_mode(read_mode), .read(read),
      .reg_datao(reg_datao), .read_rdy(read_rdy), .transfer_status(transfer_status)
   );

   always #20 clk = !clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("run stopped after %0d cycles before the tests finished", cycles);
         $display("SOME TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // sensor cycles from enable to the end of the last line
   function automatic int frame_len(input int rows, input int cols);
      return v_blank_cycles + rows * (cols + h_blank_cycles);
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("[FAIL] %s (%s): expected %h, actual %h", test_name, what, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "%s mismatch", what);
   endtask

   data_check: assert property (@(posedge clk) check_on && check_data |-> reg_datao == exp_data)
      else report_mismatch("reg_datao", exp_data, $sampled(reg_datao));
   status_check: assert property (@(posedge clk) check_on |-> transfer_status == exp_status)
      else report_mismatch("transfer_status", exp_status, $sampled(transfer_status));
   rdy_check: assert property (@(posedge clk) check_on |-> read_rdy == exp_rdy)
      else report_mismatch("read_rdy", exp_rdy, $sampled(read_rdy));

   task automatic write_reg(input logic [reg_width-1:0] addr, input logic [reg_width-1:0] val);
      @(posedge clk);
      term_addr <= term_imager;
      reg_addr  <= addr;
      reg_datai <= val;
      write     <= 1'b1;
      @(posedge clk);
      write <= 1'b0;
   endtask

   // one bus cycle, the assertions sample it at the following edge where a pop also lands
   task automatic bus_check(input logic [term_width-1:0] term, input logic [reg_width-1:0] addr,
                            input logic rmode, input logic rd, input logic care,
                            input logic [reg_width-1:0] exp_d, input logic [term_width-1:0] exp_s,
                            input logic exp_r, input string name);
      @(posedge clk);
      term_addr  <= term;
      reg_addr   <= addr;
      read_mode  <= rmode;
      read       <= rd;
      check_on   <= 1'b1;
      check_data <= care;
      exp_data   <= exp_d;
      exp_status <= exp_s;
      exp_rdy    <= exp_r;
      test_name  <= name;
      @(posedge clk);
      read       <= 1'b0;
      read_mode  <= 1'b0;
      check_on   <= 1'b0;
      check_data <= 1'b0;
   endtask

   task automatic build_expected(input int rows, input int cols, input logic [9:0] base,
                                 input stream_sel_t sel);
      logic [9:0]  pix;
      logic [15:0] even;
      int          k;
      k = 0;
      exp_q.delete();
      exp_q.push_back(32'd0);                     // first frame after enable is number 0
      for (int r = 0; r < rows; r++) begin
         for (int c = 0; c < cols; c++) begin
            pix = 10'((int'(base) + r * cols + c) % 1024);
            if (sel == sel_raw) begin
               exp_q.push_back(32'(pix));
            end else if (k % 2 == 0) begin
               even = 16'(pix);
            end else begin
               exp_q.push_back({16'(pix), even});
            end
            k++;
         end
      end
   endtask

   // the disable lands after the last pixel and before the next frame start
   task automatic run_frame(input int rows, input int cols, input logic [9:0] base,
                            input stream_sel_t sel, input bit check_ovf, input string name);
      write_reg(reg_num_rows, rows);
      write_reg(reg_num_cols, cols);
      write_reg(reg_pattern_base, 32'(base));
      write_reg(reg_stream_sel, 32'(sel));
      write_reg(reg_enable, 32'd1);
      repeat (frame_len(rows, cols) + 3) @(posedge clk);
      if (check_ovf) bus_check(term_imager, reg_status, 1'b0, 1'b0, 1'b1, 32'd1, 0, 1'b0, name);
      write_reg(reg_enable, 32'd0);
      build_expected(rows, cols, base, sel);
   endtask

   task automatic drain(input string name);
      int n;
      n = (exp_q.size() < depth) ? exp_q.size() : depth;
      for (int i = 0; i < n; i++) begin
         bus_check(term_stream, 0, 1'b1, 1'b1, 1'b1, exp_q[i], 0, 1'b1, name);
      end
      repeat (2) bus_check(term_stream, 0, 1'b1, 1'b1, 1'b0, 0, 0, 1'b0, name);
   endtask

   initial begin
      resetb    <= 1'b0;
      term_addr <= '0;
      reg_addr  <= '0;
      reg_datai <= '0;
      write     <= 1'b0;
      read_mode <= 1'b0;
      read      <= 1'b0;
      cycle_limit = frame_len(3, 4) + frame_len(2, 6) + frame_len(5, 8);
      for (int i = 0; i < 4; i++) begin
         rng = xorshift(rng);
         rnd_base[i] = rng[9:0];
         rng = xorshift(rng);
         rnd_cols[i] = 2 * (1 + int'(rng % 4));
         rng = xorshift(rng);
         rnd_rows[i] = 1 + int'(rng % 3);
         cycle_limit += 2 * frame_len(rnd_rows[i], rnd_cols[i]);
      end
      cycle_limit = 3 * cycle_limit;
      repeat (2) @(posedge clk);
      resetb <= 1'b1;

      write_reg(reg_num_rows, 32'd7);
      write_reg(reg_num_cols, 32'd9);
      write_reg(reg_pattern_base, 32'h2a5);
      write_reg(reg_stream_sel, 32'd1);
      bus_check(term_imager, reg_num_rows, 1'b0, 1'b0, 1'b1, 32'd7, 0, 1'b0, "regs rows");
      bus_check(term_imager, reg_num_cols, 1'b0, 1'b0, 1'b1, 32'd9, 0, 1'b0, "regs cols");
      bus_check(term_imager, reg_pattern_base, 1'b0, 1'b0, 1'b1, 32'h2a5, 0, 1'b0, "regs base");
      bus_check(term_imager, reg_stream_sel, 1'b0, 1'b0, 1'b1, 32'd1, 0, 1'b0, "regs sel");
      // the sensor is still in vertical blanking when it is disabled again
      write_reg(reg_enable, 32'd1);
      bus_check(term_imager, reg_enable, 1'b0, 1'b0, 1'b1, 32'd1, 0, 1'b0, "regs enable");
      write_reg(reg_enable, 32'd0);
      bus_check(16'h7, reg_num_rows, 1'b0, 1'b0, 1'b1, 32'd0, 1, 1'b0, "unknown terminal");

      // strobes on the empty buffer must leave it empty
      repeat (2) bus_check(term_stream, 0, 1'b1, 1'b1, 1'b0, 0, 0, 1'b0, "empty read");
      run_frame(3, 4, 10'h3fa, sel_raw, 1'b0, "raw capture");
      drain("raw capture");
      run_frame(2, 6, 10'h1f0, sel_packed, 1'b0, "packed capture");
      drain("packed capture");

      run_frame(5, 8, 10'h3e0, sel_raw, 1'b1, "overflow");
      bus_check(term_imager, reg_status, 1'b0, 1'b0, 1'b1, 32'd0, 0, 1'b0, "overflow clear");
      drain("overflow");

      for (int i = 0; i < 4; i++) begin
         run_frame(rnd_rows[i], rnd_cols[i], rnd_base[i], sel_raw, 1'b0, "random raw");
         drain("random raw");
         run_frame(rnd_rows[i], rnd_cols[i], rnd_base[i], sel_packed, 1'b0, "random packed");
         drain("random packed");
      end

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== design/imager_top.sv ====
module imager_top import imager_pkg::*; #(
   parameter int capture_depth = 16
) (
   input  logic                  clk,
   input  logic                  resetb,
   input  logic [term_width-1:0] term_addr,
   input  logic [reg_width-1:0]  reg_addr,
   input  logic [reg_width-1:0]  reg_datai,
   input  logic                  write,
   input  logic                  read_mode,
   input  logic                  read,
   output logic [reg_width-1:0]  reg_datao,
   output logic                  read_rdy,
   output logic [term_width-1:0] transfer_status
);
   logic                   enable;
   logic [dim_width-1:0]   num_rows;
   logic [dim_width-1:0]   num_cols;
   logic [pixel_width-1:0] pattern_base;
   stream_sel_t            stream_sel;
   logic                   fv;
   logic                   lv;
   logic [pixel_width-1:0] dat;
   logic                   rx_dv;
   dtype_t                 rx_dtype;
   logic [15:0]            rx_data;
   logic                   pk_dv;
   dtype_t                 pk_dtype;
   logic [31:0]            pk_data;
   logic                   sel_dv;
   dtype_t                 sel_dtype;
   logic [31:0]            sel_data;
   logic [reg_width-1:0]   cap_datao;
   logic                   cap_rdy;
   logic                   overflow;
   logic                   pop;

   assign pop = read && read_mode && (term_addr == term_stream);

   imager_regs regs0 (
      .clk(clk), .resetb(resetb), .term_addr(term_addr), .reg_addr(reg_addr),
      .reg_datai(reg_datai), .write(write), .read_mode(read_mode),
      .stream_datao(cap_datao), .stream_rdy(cap_rdy), .overflow(overflow),
      .reg_datao(reg_datao), .read_rdy(read_rdy), .transfer_status(transfer_status),
      .enable(enable), .num_rows(num_rows), .num_cols(num_cols),
      .pattern_base(pattern_base), .stream_sel(stream_sel)
   );

   pattern_imager imager0 (
      .clk(clk), .resetb(resetb), .enable(enable), .num_rows(num_rows),
      .num_cols(num_cols), .pattern_base(pattern_base), .fv(fv), .lv(lv), .dat(dat)
   );

   imager_rx rx0 (
      .clk(clk), .resetb(resetb), .enable(enable), .fv(fv), .lv(lv), .dat(dat),
      .dv(rx_dv), .dtype(rx_dtype), .data(rx_data)
   );

   raw_to_32 pack0 (
      .clk(clk), .resetb(resetb), .dvi(rx_dv), .dtypei(rx_dtype), .datai(rx_data),
      .dvo(pk_dv), .dtypeo(pk_dtype), .datao(pk_data)
   );

   // one register stage between the chain and the capture buffer
   always_ff @(posedge clk) begin
      if (!resetb) begin
         sel_dv    <= 1'b0;
         sel_dtype <= dtype_none;
      end else if (stream_sel == sel_raw) begin
         sel_dv    <= rx_dv;
         sel_dtype <= rx_dtype;
      end else begin
         sel_dv    <= pk_dv;
         sel_dtype <= pk_dtype;
      end
   end

   always_ff @(posedge clk) begin
      sel_data <= (stream_sel == sel_raw) ? {16'd0, rx_data} : pk_data;
   end

   stream_capture #(.capture_depth(capture_depth)) capture0 (
      .clk(clk), .resetb(resetb), .enable(enable),
      .dvi(sel_dv && sel_dtype != dtype_none), .datai(sel_data), .pop(pop),
      .datao(cap_datao), .rdy(cap_rdy), .overflow(overflow)
   );

endmodule

// ==== design/stream_capture.sv ====
module stream_capture import imager_pkg::*; #(
   parameter int capture_depth = 16
) (
   input  logic                 clk,
   input  logic                 resetb,
   input  logic                 enable,
   input  logic                 dvi,
   input  logic [reg_width-1:0] datai,
   input  logic                 pop,
   output logic [reg_width-1:0] datao,
   output logic                 rdy,
   output logic                 overflow
);
   localparam int ptr_width = (capture_depth > 1) ? $clog2(capture_depth) : 1;
   localparam int cnt_width = $clog2(capture_depth + 1);

   logic [reg_width-1:0] mem [capture_depth];
   logic [ptr_width-1:0] wr_ptr;
   logic [ptr_width-1:0] rd_ptr;
   logic [cnt_width-1:0] count;
   logic                 enable_d;
   logic                 restart;
   logic                 full;
   logic                 do_push;
   logic                 do_pop;

   function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] p);
      return (p == ptr_width'(capture_depth - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full    = (count == cnt_width'(capture_depth));
   assign rdy     = (count != 0);
   assign datao   = mem[rd_ptr];
   assign restart = enable && !enable_d;
   assign do_push = enable && dvi && !full && !restart;
   assign do_pop  = pop && rdy && !restart;

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= datai;
      end
   end

   // contents survive a disable so the host can still drain them, and the
   // buffer starts empty again when capture is re-enabled
   always_ff @(posedge clk) begin
      if (!resetb) begin
         enable_d <= 1'b0;
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         enable_d <= enable;
         if (restart) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
         end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop) begin
               count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
               count <= count - 1'b1;
            end
         end
         if (!enable) begin
            overflow <= 1'b0;
         end else if (dvi && full) begin
            overflow <= 1'b1;                     // word dropped, sensor cannot stall
         end
      end
   end

endmodule

// ==== design/raw_to_32.sv ====
module raw_to_32 import imager_pkg::*; (
   input  logic        clk,
   input  logic        resetb,
   input  logic        dvi,
   input  dtype_t      dtypei,
   input  logic [15:0] datai,
   output logic        dvo,
   output dtype_t      dtypeo,
   output logic [31:0] datao
);
   logic        odd;                              // high when the even pixel is held
   logic [15:0] even_pix;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         odd    <= 1'b0;
         dvo    <= 1'b0;
         dtypeo <= dtype_none;
      end else if (dvi && dtypei == dtype_frame_start) begin
         odd    <= 1'b0;
         dvo    <= 1'b1;
         dtypeo <= dtype_frame_start;
         datao  <= {16'd0, datai};
      end else if (dvi && dtypei == dtype_pixel) begin
         odd    <= !odd;
         dvo    <= odd;
         dtypeo <= odd ? dtype_pixel : dtype_none;
         if (odd) begin
            datao <= {datai, even_pix};
         end else begin
            even_pix <= datai;
         end
      end else begin
         dvo    <= 1'b0;
         dtypeo <= dtype_none;
      end
   end

endmodule

// ==== design/imager_rx.sv ====
module imager_rx import imager_pkg::*; (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic                   enable,
   input  logic                   fv,
   input  logic                   lv,
   input  logic [pixel_width-1:0] dat,
   output logic                   dv,
   output dtype_t                 dtype,
   output logic [15:0]            data
);
   logic        fv_d;
   logic [15:0] frame_cnt;
   logic        frame_start;

   assign frame_start = fv && !fv_d;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         fv_d      <= 1'b0;
         frame_cnt <= '0;
         dv        <= 1'b0;
         dtype     <= dtype_none;
      end else begin
         fv_d <= fv;
         if (!enable) begin
            frame_cnt <= '0;                      // frame numbers restart at each enable
            dv        <= 1'b0;
            dtype     <= dtype_none;
         end else if (frame_start) begin
            frame_cnt <= frame_cnt + 1'b1;
            dv        <= 1'b1;
            dtype     <= dtype_frame_start;
         end else if (lv) begin
            dv    <= 1'b1;
            dtype <= dtype_pixel;
         end else begin
            dv    <= 1'b0;
            dtype <= dtype_none;
         end
      end
   end

   // payload register, only meaningful while dv is high
   always_ff @(posedge clk) begin
      if (frame_start) begin
         data <= frame_cnt;
      end else if (lv) begin
         data <= 16'(dat);
      end
   end

endmodule

// ==== design/pattern_imager.sv ====
module pattern_imager import imager_pkg::*; (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic                   enable,
   input  logic [dim_width-1:0]   num_rows,
   input  logic [dim_width-1:0]   num_cols,
   input  logic [pixel_width-1:0] pattern_base,
   output logic                   fv,
   output logic                   lv,
   output logic [pixel_width-1:0] dat
);
   typedef enum logic [1:0] {idle, line, h_blank, v_blank} state_t;

   state_t                 state;
   logic [dim_width-1:0]   row;
   logic [dim_width-1:0]   col;
   logic [3:0]             blank_cnt;
   logic [pixel_width-1:0] pix;                   // running pixel index plus base, wraps at 1024
   logic                   last_v_blank;

   assign last_v_blank = (state == v_blank) && (blank_cnt == 4'(v_blank_cycles - 1));

   // fv rises on the last vertical blank cycle so the receiver sees it one cycle before lv
   assign fv  = (state == line) || (state == h_blank) || last_v_blank;
   assign lv  = (state == line);
   assign dat = pix;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state     <= idle;
         row       <= '0;
         col       <= '0;
         blank_cnt <= '0;
      end else if (!enable) begin
         state <= idle;                           // a disable abandons the frame in flight
      end else begin
         case (state)
            idle: begin
               if (num_rows != 0 && num_cols != 0) begin
                  state     <= v_blank;
                  blank_cnt <= '0;
               end
            end
            v_blank: begin
               if (last_v_blank) begin
                  state <= line;
                  row   <= '0;
                  col   <= '0;
                  pix   <= pattern_base;
               end else begin
                  blank_cnt <= blank_cnt + 1'b1;
               end
            end
            line: begin
               pix <= pix + 1'b1;
               if (col == num_cols - 1'b1) begin
                  state     <= h_blank;
                  col       <= '0;
                  blank_cnt <= '0;
               end else begin
                  col <= col + 1'b1;
               end
            end
            h_blank: begin
               if (blank_cnt == 4'(h_blank_cycles - 1)) begin
                  blank_cnt <= '0;
                  if (row == num_rows - 1'b1) begin
                     state <= v_blank;
                  end else begin
                     row   <= row + 1'b1;
                     state <= line;
                  end
               end else begin
                  blank_cnt <= blank_cnt + 1'b1;
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

// ==== design/imager_regs.sv ====
module imager_regs import imager_pkg::*; (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic [term_width-1:0]  term_addr,
   input  logic [reg_width-1:0]   reg_addr,
   input  logic [reg_width-1:0]   reg_datai,
   input  logic                   write,
   input  logic                   read_mode,
   input  logic [reg_width-1:0]   stream_datao,
   input  logic                   stream_rdy,
   input  logic                   overflow,
   output logic [reg_width-1:0]   reg_datao,
   output logic                   read_rdy,
   output logic [term_width-1:0]  transfer_status,
   output logic                   enable,
   output logic [dim_width-1:0]   num_rows,
   output logic [dim_width-1:0]   num_cols,
   output logic [pixel_width-1:0] pattern_base,
   output stream_sel_t            stream_sel
);
   logic [reg_width-1:0] ctrl_data;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         enable       <= 1'b0;
         num_rows     <= '0;
         num_cols     <= '0;
         pattern_base <= '0;
         stream_sel   <= sel_raw;
      end else if (write && term_addr == term_imager) begin
         case (reg_addr)
            reg_enable:       enable       <= reg_datai[0];
            reg_num_rows:     num_rows     <= reg_datai[dim_width-1:0];
            reg_num_cols:     num_cols     <= reg_datai[dim_width-1:0];
            reg_pattern_base: pattern_base <= reg_datai[pixel_width-1:0];
            reg_stream_sel:   stream_sel   <= stream_sel_t'(reg_datai[0]);
            default: ;                                    // status is read only
         endcase
      end
   end

   always_comb begin
      case (reg_addr)
         reg_enable:       ctrl_data = reg_width'(enable);
         reg_num_rows:     ctrl_data = reg_width'(num_rows);
         reg_num_cols:     ctrl_data = reg_width'(num_cols);
         reg_pattern_base: ctrl_data = reg_width'(pattern_base);
         reg_stream_sel:   ctrl_data = reg_width'(stream_sel);
         reg_status:       ctrl_data = reg_width'(overflow);
         default:          ctrl_data = '0;
      endcase
   end

   // the stream terminal is only ready when the capture FIFO holds a word
   always_comb begin
      if (term_addr == term_imager) begin
         reg_datao       = ctrl_data;
         read_rdy        = read_mode;
         transfer_status = '0;
      end else if (term_addr == term_stream) begin
         reg_datao       = stream_datao;
         read_rdy        = read_mode && stream_rdy;
         transfer_status = '0;
      end else begin
         reg_datao       = '0;
         read_rdy        = read_mode;
         transfer_status = term_width'(1);
      end
   end

endmodule

// ==== design/imager_pkg.sv ====
package imager_pkg;

   localparam int pixel_width = 10;
   localparam int dim_width   = 12;
   localparam int reg_width   = 32;
   localparam int term_width  = 16;

   // terminal 0 is left unused so an idle host bus reads as an unknown terminal
   localparam logic [term_width-1:0] term_imager = 16'd1;
   localparam logic [term_width-1:0] term_stream = 16'd2;

   localparam logic [reg_width-1:0] reg_enable       = 32'd0;
   localparam logic [reg_width-1:0] reg_num_rows     = 32'd1;
   localparam logic [reg_width-1:0] reg_num_cols     = 32'd2;
   localparam logic [reg_width-1:0] reg_pattern_base = 32'd3;
   localparam logic [reg_width-1:0] reg_stream_sel   = 32'd4;
   localparam logic [reg_width-1:0] reg_status       = 32'd5; // bit 0 is the sticky overflow

   typedef enum logic [1:0] {
      dtype_none        = 2'd0,
      dtype_frame_start = 2'd1,
      dtype_pixel       = 2'd2
   } dtype_t;

   typedef enum logic {
      sel_raw    = 1'b0,
      sel_packed = 1'b1
   } stream_sel_t;

   localparam int h_blank_cycles = 4;
   localparam int v_blank_cycles = 8;

endpackage
